// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_OP_W   = 2;

    // Software operation codes
    localparam logic [CSR_OP_W-1:0] CSR_OP_NONE  = 2'd0;
    localparam logic [CSR_OP_W-1:0] CSR_OP_WRITE = 2'd1;
    localparam logic [CSR_OP_W-1:0] CSR_OP_SET   = 2'd2;
    localparam logic [CSR_OP_W-1:0] CSR_OP_CLEAR = 2'd3;

    // ==================================================
    // CSR addresses
    // ==================================================
    // Machine read/write registers
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;

    // User counters, read only
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE     = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET   = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRETH  = 12'hC82;

    // Identity registers, always zero
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF14;

    // ==================================================
    // Exception cause codes
    // ==================================================
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT    = 32'd3;
    localparam logic [XLEN-1:0] CAUSE_MISALIGNED    = 32'd4;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_CSR   = 32'd11;

endpackage

`default_nettype wire

// File: csr_counters.sv
`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                inst_valid,
    output logic [2*XLEN-1:0]   cycle_count,
    output logic [2*XLEN-1:0]   instret_count
);

    localparam int CNT_W = 2 * XLEN;

    // ==================================================
    // Cycle counter
    // ==================================================
    // Free running, counts every edge once reset is released
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + CNT_W'(1);
        end
    end

    // ==================================================
    // Retired instruction counter
    // ==================================================
    // One step per valid instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instret_count <= '0;
        end else if (inst_valid) begin
            instret_count <= instret_count + CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: csr_trap_unit.sv
`default_nettype none

module csr_trap_unit
    import csr_pkg::*;
(
    input  logic              illegal_instr,
    input  logic              misaligned,
    input  logic              illegal_csr,
    input  logic              breakpoint,
    input  logic              timer_irq,
    input  logic              ext_irq,
    output logic              trap_write,
    output logic [XLEN-1:0]   trap_cause,
    output logic              trap_jump
);

    logic any_exception;
    logic any_irq;

    // ==================================================
    // Exception priority
    // ==================================================
    // Breakpoint wins, illegal instruction is last
    always_comb begin
        trap_cause = '0;
        if (breakpoint) begin
            trap_cause = CAUSE_BREAKPOINT;
        end else if (illegal_csr) begin
            trap_cause = CAUSE_ILLEGAL_CSR;
        end else if (misaligned) begin
            trap_cause = CAUSE_MISALIGNED;
        end else if (illegal_instr) begin
            trap_cause = CAUSE_ILLEGAL_INSTR;
        end
    end

    assign any_exception = breakpoint | illegal_csr | misaligned | illegal_instr;
    assign any_irq       = timer_irq | ext_irq;

    // Only exceptions update mepc and mcause
    assign trap_write = any_exception;

    // Interrupts still redirect fetch to mtvec
    assign trap_jump = any_exception | any_irq;

endmodule

`default_nettype wire

// File: csr_regfile.sv
`default_nettype none

module csr_regfile
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] MSCRATCH_RESET = 32'h0000_1001
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    csr_wren,
    input  logic [CSR_OP_W-1:0]     csr_op,
    input  logic [CSR_ADDR_W-1:0]   csr_addr,
    input  logic                    csr_imm_bit,
    input  logic [XLEN-1:0]         csr_imm,
    input  logic [XLEN-1:0]         csr_wdata,
    input  logic [XLEN-1:0]         pc,
    input  logic                    trap_write,
    input  logic [XLEN-1:0]         trap_cause,
    output logic [XLEN-1:0]         mstatus,
    output logic [XLEN-1:0]         mie,
    output logic [XLEN-1:0]         mtvec,
    output logic [XLEN-1:0]         mscratch,
    output logic [XLEN-1:0]         mepc,
    output logic [XLEN-1:0]         mcause
);

    logic [XLEN-1:0] wr_data;

    logic [XLEN-1:0] mstatus_nxt;
    logic [XLEN-1:0] mie_nxt;
    logic [XLEN-1:0] mtvec_nxt;
    logic [XLEN-1:0] mscratch_nxt;
    logic [XLEN-1:0] mepc_nxt;
    logic [XLEN-1:0] mcause_nxt;

    // Write, set or clear on one register value
    function automatic logic [XLEN-1:0] apply_op(
        input logic [XLEN-1:0]     cur,
        input logic [CSR_OP_W-1:0] op,
        input logic [XLEN-1:0]     data
    );
        logic [XLEN-1:0] res;
        case (op)
            CSR_OP_NONE:  res = cur;
            CSR_OP_WRITE: res = data;
            CSR_OP_SET:   res = cur | data;
            CSR_OP_CLEAR: res = cur & ~data;
        endcase
        return res;
    endfunction

    // csrrwi/csrrsi/csrrci take the immediate
    assign wr_data = csr_imm_bit ? csr_imm : csr_wdata;

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        mstatus_nxt  = mstatus;
        mie_nxt      = mie;
        mtvec_nxt    = mtvec;
        mscratch_nxt = mscratch;
        mepc_nxt     = mepc;
        mcause_nxt   = mcause;

        // Read-only and unknown addresses fall through
        if (csr_wren) begin
            case (csr_addr)
                CSR_MSTATUS:  mstatus_nxt  = apply_op(mstatus, csr_op, wr_data);
                CSR_MIE:      mie_nxt      = apply_op(mie, csr_op, wr_data);
                CSR_MTVEC:    mtvec_nxt    = apply_op(mtvec, csr_op, wr_data);
                CSR_MSCRATCH: mscratch_nxt = apply_op(mscratch, csr_op, wr_data);
                CSR_MEPC:     mepc_nxt     = apply_op(mepc, csr_op, wr_data);
                CSR_MCAUSE:   mcause_nxt   = apply_op(mcause, csr_op, wr_data);
                default: ;
            endcase
        end

        // Exception capture overrides software
        if (trap_write) begin
            mepc_nxt   = pc;
            mcause_nxt = trap_cause;
        end
    end

    // ==================================================
    // Registers
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= MSCRATCH_RESET;
            mepc     <= '0;
            mcause   <= '0;
        end else begin
            mstatus  <= mstatus_nxt;
            mie      <= mie_nxt;
            mtvec    <= mtvec_nxt;
            mscratch <= mscratch_nxt;
            mepc     <= mepc_nxt;
            mcause   <= mcause_nxt;
        end
    end

endmodule

`default_nettype wire

// File: csr_read_mux.sv
`default_nettype none

module csr_read_mux
    import csr_pkg::*;
(
    input  logic                    csr_rden,
    input  logic [CSR_ADDR_W-1:0]   csr_addr,
    input  logic [XLEN-1:0]         mstatus,
    input  logic [XLEN-1:0]         mie,
    input  logic [XLEN-1:0]         mtvec,
    input  logic [XLEN-1:0]         mscratch,
    input  logic [XLEN-1:0]         mepc,
    input  logic [XLEN-1:0]         mcause,
    input  logic [2*XLEN-1:0]       cycle_count,
    input  logic [2*XLEN-1:0]       instret_count,
    output logic [XLEN-1:0]         csr_rdata
);

    // ==================================================
    // Read decode
    // ==================================================
    always_comb begin
        csr_rdata = '0;
        if (csr_rden) begin
            case (csr_addr)
                // Machine registers
                CSR_MSTATUS:  csr_rdata = mstatus;
                CSR_MIE:      csr_rdata = mie;
                CSR_MTVEC:    csr_rdata = mtvec;
                CSR_MSCRATCH: csr_rdata = mscratch;
                CSR_MEPC:     csr_rdata = mepc;
                CSR_MCAUSE:   csr_rdata = mcause;

                // Counter halves
                CSR_CYCLE:    csr_rdata = cycle_count[XLEN-1:0];
                CSR_CYCLEH:   csr_rdata = cycle_count[2*XLEN-1:XLEN];
                CSR_INSTRET:  csr_rdata = instret_count[XLEN-1:0];
                CSR_INSTRETH: csr_rdata = instret_count[2*XLEN-1:XLEN];

                // No vendor, arch, impl or hart id in this core
                CSR_MVENDORID,
                CSR_MARCHID,
                CSR_MIMPID,
                CSR_MHARTID:  csr_rdata = '0;

                default:      csr_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: csr_top.sv
`default_nettype none

module csr_top
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] MSCRATCH_RESET = 32'h0000_1001
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [XLEN-1:0]         pc,
    input  logic                    csr_rden,
    input  logic                    csr_wren,
    input  logic [CSR_OP_W-1:0]     csr_op,
    input  logic [CSR_ADDR_W-1:0]   csr_addr,
    input  logic                    csr_imm_bit,
    input  logic [XLEN-1:0]         csr_imm,
    input  logic [XLEN-1:0]         csr_wdata,
    input  logic                    inst_valid,
    input  logic                    illegal_instr,
    input  logic                    misaligned,
    input  logic                    illegal_csr,
    input  logic                    breakpoint,
    input  logic                    timer_irq,
    input  logic                    ext_irq,
    input  logic                    mret,
    output logic [XLEN-1:0]         csr_rdata,
    output logic                    trap_jump,
    output logic [XLEN-1:0]         trap_addr,
    output logic                    trap_return,
    output logic [XLEN-1:0]         return_addr
);

    logic              trap_write;
    logic [XLEN-1:0]   trap_cause;
    logic [2*XLEN-1:0] cycle_count;
    logic [2*XLEN-1:0] instret_count;
    logic [XLEN-1:0]   mstatus;
    logic [XLEN-1:0]   mie;
    logic [XLEN-1:0]   mtvec;
    logic [XLEN-1:0]   mscratch;
    logic [XLEN-1:0]   mepc;
    logic [XLEN-1:0]   mcause;

    csr_counters u_counters (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    csr_trap_unit u_trap_unit (
        .illegal_instr (illegal_instr),
        .misaligned    (misaligned),
        .illegal_csr   (illegal_csr),
        .breakpoint    (breakpoint),
        .timer_irq     (timer_irq),
        .ext_irq       (ext_irq),
        .trap_write    (trap_write),
        .trap_cause    (trap_cause),
        .trap_jump     (trap_jump)
    );

    csr_regfile #(
        .MSCRATCH_RESET (MSCRATCH_RESET)
    ) u_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .csr_wren    (csr_wren),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_imm_bit (csr_imm_bit),
        .csr_imm     (csr_imm),
        .csr_wdata   (csr_wdata),
        .pc          (pc),
        .trap_write  (trap_write),
        .trap_cause  (trap_cause),
        .mstatus     (mstatus),
        .mie         (mie),
        .mtvec       (mtvec),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause)
    );

    csr_read_mux u_read_mux (
        .csr_rden      (csr_rden),
        .csr_addr      (csr_addr),
        .mstatus       (mstatus),
        .mie           (mie),
        .mtvec         (mtvec),
        .mscratch      (mscratch),
        .mepc          (mepc),
        .mcause        (mcause),
        .cycle_count   (cycle_count),
        .instret_count (instret_count),
        .csr_rdata     (csr_rdata)
    );

    // PC redirect targets
    assign trap_addr   = mtvec;
    assign return_addr = mepc;
    assign trap_return = mret;

endmodule

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: csr_checker.sv
`default_nettype none

module csr_checker
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] MSCRATCH_RESET = 32'h0000_1001
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [XLEN-1:0]       pc,
    input  logic                  csr_rden,
    input  logic                  csr_wren,
    input  logic [CSR_OP_W-1:0]   csr_op,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic                  csr_imm_bit,
    input  logic [XLEN-1:0]       csr_imm,
    input  logic [XLEN-1:0]       csr_wdata,
    input  logic                  inst_valid,
    input  logic                  illegal_instr,
    input  logic                  misaligned,
    input  logic                  illegal_csr,
    input  logic                  breakpoint,
    input  logic                  timer_irq,
    input  logic                  ext_irq,
    input  logic                  mret,
    input  logic [XLEN-1:0]       csr_rdata,
    input  logic                  trap_jump,
    input  logic [XLEN-1:0]       trap_addr,
    input  logic                  trap_return,
    input  logic [XLEN-1:0]       return_addr,
    input  logic [2:0]            test_id,
    output int                    tests_run,
    output int                    tests_failed,
    output int                    error_count
);

    // ==================================================
    // Reference model state
    // ==================================================
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;

    logic [2:0] cur_test = 3'd0;
    int         test_errs = 0;
    int         n_tests = 0;
    int         n_failed = 0;
    int         n_errors = 0;

    assign tests_run    = n_tests;
    assign tests_failed = n_failed;
    assign error_count  = n_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset values";
            3'd2:    return "software operations";
            3'd3:    return "counters";
            3'd4:    return "exceptions";
            3'd5:    return "interrupts and mret";
            3'd6:    return "empty reads";
            default: return "unnamed";
        endcase
    endfunction

    // Write replaces, set ORs in, clear removes bits
    function automatic logic [31:0] next_value(input logic [31:0] cur, input logic [31:0] d);
        case (csr_op)
            CSR_OP_WRITE: return d;
            CSR_OP_SET:   return cur | d;
            CSR_OP_CLEAR: return cur & ~d;
            default:      return cur;
        endcase
    endfunction

    // Breakpoint highest, illegal instruction lowest
    function automatic logic [31:0] exception_cause();
        if (breakpoint) return 32'd3;
        if (illegal_csr) return 32'd11;
        if (misaligned) return 32'd4;
        return 32'd2;
    endfunction

    // Identity registers and unknown addresses both read zero
    function automatic logic [31:0] expected_read();
        if (!csr_rden) return 32'd0;
        case (csr_addr)
            12'h300: return m_mstatus;
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'hC00: return m_cycle[31:0];
            12'hC80: return m_cycle[63:32];
            12'hC02: return m_instret[31:0];
            12'hC82: return m_instret[63:32];
            default: return 32'd0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            n_errors++;
            test_errs++;
        end
    endtask

    task automatic reset_model();
        m_mstatus  = '0;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mscratch = MSCRATCH_RESET;
        m_mepc     = '0;
        m_mcause   = '0;
        m_cycle    = '0;
        m_instret  = '0;
    endtask

    task automatic check_outputs();
        logic any_cause;
        any_cause = illegal_instr | misaligned | illegal_csr | breakpoint | timer_irq | ext_irq;
        compare("csr_rdata", expected_read(), csr_rdata);
        compare("trap_jump", 32'(any_cause), 32'(trap_jump));
        compare("trap_addr", m_mtvec, trap_addr);
        compare("trap_return", 32'(mret), 32'(trap_return));
        compare("return_addr", m_mepc, return_addr);
    endtask

    task automatic update_model();
        logic [31:0] d;
        d = csr_imm_bit ? csr_imm : csr_wdata;
        if (csr_wren) begin
            case (csr_addr)
                12'h300: m_mstatus  = next_value(m_mstatus, d);
                12'h304: m_mie      = next_value(m_mie, d);
                12'h305: m_mtvec    = next_value(m_mtvec, d);
                12'h340: m_mscratch = next_value(m_mscratch, d);
                12'h341: m_mepc     = next_value(m_mepc, d);
                12'h342: m_mcause   = next_value(m_mcause, d);
                default: ;
            endcase
        end
        // Exception capture wins over software
        if (illegal_instr | misaligned | illegal_csr | breakpoint) begin
            m_mepc   = pc;
            m_mcause = exception_cause();
        end
        m_cycle = m_cycle + 64'd1;
        if (inst_valid) begin
            m_instret = m_instret + 64'd1;
        end
    endtask

    task automatic close_test();
        n_tests++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", cur_test, test_name(cur_test));
        end else begin
            n_failed++;
            $display("test %0d %s: %0d mismatches", cur_test, test_name(cur_test), test_errs);
        end
    endtask

    // ==================================================
    // Per-edge compare and model step
    // ==================================================
    // The stimulus seen at this edge belongs to test_id
    always @(posedge clk) begin
        if (test_id != cur_test) begin
            if (cur_test != 3'd0) begin
                close_test();
            end
            cur_test  = test_id;
            test_errs = 0;
        end
        if (!arst_n) begin
            reset_model();
        end else begin
            check_outputs();
            update_model();
        end
    end

endmodule

`default_nettype wire

// File: csr_assert.sv
`default_nettype none

module csr_assert (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        illegal_instr,
    input  logic        misaligned,
    input  logic        illegal_csr,
    input  logic        breakpoint,
    input  logic        timer_irq,
    input  logic        ext_irq,
    input  logic        mret,
    input  logic        trap_jump,
    input  logic        trap_return,
    input  logic [31:0] cycle_lo
);

    // Any exception or interrupt redirects fetch
    a_trap_jump: assert property (@(posedge clk) disable iff (!arst_n)
        trap_jump == (illegal_instr | misaligned | illegal_csr | breakpoint
                      | timer_irq | ext_irq))
        else $error("trap_jump does not match the exception and interrupt inputs");

    a_trap_return: assert property (@(posedge clk) disable iff (!arst_n)
        trap_return == mret)
        else $error("trap_return does not follow mret");

    // One step per edge once the previous edge was out of reset
    a_cycle_step: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> cycle_lo == $past(cycle_lo) + 32'd1)
        else $error("cycle counter did not advance by one");

endmodule

bind csr_top csr_assert u_assert (
    .clk           (clk),
    .arst_n        (arst_n),
    .illegal_instr (illegal_instr),
    .misaligned    (misaligned),
    .illegal_csr   (illegal_csr),
    .breakpoint    (breakpoint),
    .timer_irq     (timer_irq),
    .ext_irq       (ext_irq),
    .mret          (mret),
    .trap_jump     (trap_jump),
    .trap_return   (trap_return),
    .cycle_lo      (cycle_count[31:0])
);

`default_nettype wire

// File: csr_tb.sv
`default_nettype none

module csr_tb
    import csr_pkg::*;
;

    localparam logic [XLEN-1:0] MSCRATCH_RESET = 32'h0000_1001;
    localparam int RESET_CYCLES = 10;

    // ==================================================
    // Test lengths and run limit
    // ==================================================
    localparam int T1_LEN = 10;
    localparam int T2_LEN = 300;
    localparam int T3_LEN = 200;
    localparam int T4_LEN = 100;
    localparam int T5_LEN = 100;
    localparam int T6_LEN = 100;
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT_LIMIT = RESET_CYCLES + T1_LEN + T2_LEN + T3_LEN + T4_LEN
                                 + T5_LEN + T6_LEN + 100;

    logic                  clk;
    logic                  arst_n;
    logic [XLEN-1:0]       pc;
    logic                  csr_rden;
    logic                  csr_wren;
    logic [CSR_OP_W-1:0]   csr_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  csr_imm_bit;
    logic [XLEN-1:0]       csr_imm;
    logic [XLEN-1:0]       csr_wdata;
    logic                  inst_valid;
    logic                  illegal_instr;
    logic                  misaligned;
    logic                  illegal_csr;
    logic                  breakpoint;
    logic                  timer_irq;
    logic                  ext_irq;
    logic                  mret;
    logic [XLEN-1:0]       csr_rdata;
    logic                  trap_jump;
    logic [XLEN-1:0]       trap_addr;
    logic                  trap_return;
    logic [XLEN-1:0]       return_addr;

    logic [2:0] test_id;
    int         tests_run;
    int         tests_failed;
    int         error_count;
    integer     seed = 32'h9629_4918;
    int         cycle_cnt = 0;

    tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

    csr_top #(.MSCRATCH_RESET(MSCRATCH_RESET)) uut (.*);

    csr_checker #(.MSCRATCH_RESET(MSCRATCH_RESET)) u_checker (.*);

    task automatic draw_random(output logic [31:0] r);
        r = $random(seed);
    endtask

    // Quiet value for every per-cycle control
    task automatic idle_inputs();
        csr_rden      = 1'b0;
        csr_wren      = 1'b0;
        csr_op        = CSR_OP_NONE;
        csr_imm_bit   = 1'b0;
        inst_valid    = 1'b0;
        illegal_instr = 1'b0;
        misaligned    = 1'b0;
        illegal_csr   = 1'b0;
        breakpoint    = 1'b0;
        timer_irq     = 1'b0;
        ext_irq       = 1'b0;
        mret          = 1'b0;
    endtask

    function automatic logic [CSR_ADDR_W-1:0] pick_rw_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return CSR_MSTATUS;
            3'd1:    return CSR_MIE;
            3'd2:    return CSR_MTVEC;
            3'd3:    return CSR_MEPC;
            3'd4:    return CSR_MCAUSE;
            default: return CSR_MSCRATCH;
        endcase
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] pick_fixed_addr(input int idx);
        case (idx)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MSCRATCH;
            4:       return CSR_MEPC;
            5:       return CSR_MCAUSE;
            6:       return CSR_MVENDORID;
            7:       return CSR_MARCHID;
            8:       return CSR_MIMPID;
            default: return CSR_MHARTID;
        endcase
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] pick_counter_addr(input logic [1:0] sel);
        case (sel)
            2'd0:    return CSR_CYCLE;
            2'd1:    return CSR_CYCLEH;
            2'd2:    return CSR_INSTRET;
            default: return CSR_INSTRETH;
        endcase
    endfunction

    // ==================================================
    // Stimulus for one cycle of one test
    // ==================================================
    task automatic drive_cycle(input logic [2:0] id, input int idx);
        logic [31:0] r;
        logic [31:0] r2;
        idle_inputs();
        draw_random(r);
        draw_random(r2);
        test_id = id;
        pc      = r2;
        case (id)
            3'd1: begin
                csr_rden = 1'b1;
                csr_addr = pick_fixed_addr(idx);
            end
            3'd2: begin
                csr_rden    = 1'b1;
                csr_wren    = 1'b1;
                csr_op      = r[1:0];
                csr_imm_bit = r[2];
                csr_imm     = {27'd0, r[20:16]};
                csr_wdata   = r2;
                // Now and then aim at a read-only register
                if (r[11:8] == 4'd0) begin
                    csr_addr = r[3] ? CSR_CYCLE : CSR_MVENDORID;
                end else begin
                    csr_addr = pick_rw_addr(r[14:12]);
                end
            end
            3'd3: begin
                inst_valid = r[0];
                csr_rden   = 1'b1;
                csr_addr   = pick_counter_addr(r[2:1]);
            end
            3'd4: begin
                if (r[7:6] != 2'b00) begin
                    illegal_instr = r[0];
                    misaligned    = r[1];
                    illegal_csr   = r[2];
                    breakpoint    = r[3];
                end
                csr_rden  = 1'b1;
                csr_wren  = r[8];
                csr_op    = CSR_OP_WRITE;
                csr_addr  = r[9] ? CSR_MEPC : CSR_MCAUSE;
                csr_wdata = r[31:0] ^ r2;
            end
            3'd5: begin
                timer_irq = r[0] & r[1];
                ext_irq   = r[2] & r[3];
                mret      = r[4];
                csr_rden  = 1'b1;
                csr_addr  = r[5] ? CSR_MEPC : CSR_MCAUSE;
            end
            default: begin
                csr_rden = r[0];
                csr_addr = r[1] ? r[27:16] : pick_fixed_addr(int'(r[4:2]));
            end
        endcase
    endtask

    task automatic run_test(input logic [2:0] id, input int len);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            drive_cycle(id, i);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Run limit
    initial begin
        wait (cycle_cnt >= TIMEOUT_LIMIT);
        $display("Run stopped: no result after %0d clock cycles", TIMEOUT_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n    = 1'b0;
        test_id   = 3'd0;
        pc        = '0;
        csr_addr  = '0;
        csr_imm   = '0;
        csr_wdata = '0;
        idle_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        run_test(3'd1, T1_LEN);
        run_test(3'd2, T2_LEN);
        run_test(3'd3, T3_LEN);
        run_test(3'd4, T4_LEN);
        run_test(3'd5, T5_LEN);
        run_test(3'd6, T6_LEN);

        // Idle lets the checker close the last test
        @(negedge clk);
        idle_inputs();
        test_id = 3'd0;
        repeat (2) @(negedge clk);

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, error_count);
        if (tests_run == NUM_TESTS && tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
csr_pkg.sv
csr_counters.sv
csr_trap_unit.sv
csr_regfile.sv
csr_read_mux.sv
csr_top.sv
tb_clock.sv
csr_checker.sv
csr_assert.sv
csr_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module csr_tb -f files.f -o csr_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/csr_sim)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
